// File: src.f
+incdir+include
hw/conv_pkg.sv
hw/conv_ifs.sv
hw/conv_apb_regs.sv
hw/line_buffer.sv
hw/window_buffer.sv
hw/conv_mac.sv
hw/conv5x5_top.sv
verif/tb_conv5x5.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_conv5x5 -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_conv5x5 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: verif/tb_conv5x5.sv
`timescale 1ns/1ps
`include "conv_regs.svh"

module tb_conv5x5;

  localparam int COLS    = 8;
  localparam int ROWS    = 7;
  localparam int NPIX    = COLS * ROWS;
  localparam int NOUT    = (COLS - 4) * (ROWS - 4);
  localparam int CLK_PER = 40;
  localparam int TIMEOUT = 20 * 6 * NPIX * CLK_PER + 50000;  // Six frames plus APB traffic.

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        pix_valid;
  logic [7:0]  pix_data;
  logic        pix_ready;
  logic        out_valid;
  logic [7:0]  out_data;

  logic [7:0] img [ROWS][COLS];
  int         coef [25];
  int         seed = 32'h78b6_b563;
  int         errors = 0;
  int         tests = 0;
  int         out_cnt = 0;
  int         exp_q [$];
  int         got_q [$];
  int         saved_q [$];

  conv5x5_top #(.COLS(COLS), .ROWS(ROWS)) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .pix_valid_i (pix_valid),
    .pix_data_i  (pix_data),
    .pix_ready_o (pix_ready),
    .out_valid_o (out_valid),
    .out_data_o  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PER / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s: got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    #2;
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    err = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    #2;
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    data = prdata;  // Read data is valid in the access phase.
    err  = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Window whose bottom-right corner is pixel (x, y).
  function automatic int ref_conv(input int x, input int y, input int sh);
    int sum;
    int res;
    sum = 0;
    for (int r = 0; r < 5; r++) begin
      for (int c = 0; c < 5; c++) begin
        sum += int'(img[y - 4 + r][x - 4 + c]) * coef[r * 5 + c];
      end
    end
    res = sum >>> sh;
    if (res < 0) begin
      res = 0;
    end else if (res > 255) begin
      res = 255;
    end
    return res;
  endfunction

  task automatic queue_expected(input int npix, input int sh);
    for (int i = 0; i < npix; i++) begin
      if (i % COLS >= 4 && i / COLS >= 4) begin
        exp_q.push_back(ref_conv(i % COLS, i / COLS, sh));
      end
    end
  endtask

  task automatic send_frame(input int npix, input bit gaps);
    for (int i = 0; i < npix; i++) begin
      while (gaps && (($random(seed) & 3) == 0)) begin
        @(posedge clk);
        #2;
        pix_valid = 1'b0;
      end
      @(posedge clk);
      #2;
      pix_valid = 1'b1;
      pix_data  = img[i / COLS][i % COLS];
    end
    @(posedge clk);
    #2;
    pix_valid = 1'b0;
  endtask

  task automatic wait_outputs();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("missing outputs: %0d expected pixels never appeared", exp_q.size());
      errors++;
      exp_q.delete();
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic program_coefs(input int sh);
    logic err;
    for (int k = 0; k < 25; k++) begin
      apb_write(`CONV_REG_COEF(k), {24'h0, 8'(coef[k])}, err);
      check_value(32'(err), 0, "pslverr on coefficient write");
    end
    apb_write(`CONV_REG_SHIFT, 32'(sh), err);
    check_value(32'(err), 0, "pslverr on shift write");
  endtask

  task automatic random_coefs();
    for (int k = 0; k < 25; k++) begin
      coef[k] = int'(byte'($random(seed)));
    end
  endtask

  task automatic fill_random_image();
    for (int y = 0; y < ROWS; y++) begin
      for (int x = 0; x < COLS; x++) begin
        img[y][x] = 8'($random(seed));
      end
    end
  endtask

  // Small kernels keep the shifted sums near the pixel range.
  task automatic pick_random_kernel(input int sh);
    int  v;
    int  n_lo;
    int  n_mid;
    int  n_hi;
    bit  found;
    found = 1'b0;
    for (int t = 0; t < 20 && !found; t++) begin
      n_lo  = 0;
      n_mid = 0;
      n_hi  = 0;
      for (int k = 0; k < 25; k++) begin
        coef[k] = $random(seed) % 8;
      end
      fill_random_image();
      for (int y = 4; y < ROWS; y++) begin
        for (int x = 4; x < COLS; x++) begin
          v = ref_conv(x, y, sh);
          if (v == 0) begin
            n_lo++;
          end else if (v == 255) begin
            n_hi++;
          end else begin
            n_mid++;
          end
        end
      end
      found = (n_lo != 0) && (n_mid != 0) && (n_hi != 0);
    end
    if (!found) begin
      $display("no random kernel reached both clamps and the linear range");
      errors++;
    end
  endtask

  task automatic run_frame(input int npix, input bit gaps, input int sh);
    logic err;
    apb_write(`CONV_REG_CTRL, 32'h3, err);  // Enable and restart.
    check_value(32'(pix_ready), 1, "pix_ready_o while enabled");
    out_cnt = 0;
    got_q.delete();
    queue_expected(npix, sh);
    send_frame(npix, gaps);
    wait_outputs();
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err0);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      out_cnt++;
      got_q.push_back(int'(out_data));
      if (exp_q.size() == 0) begin
        $display("unexpected output %0h at %0t with no pixel expected", out_data, $time);
        errors++;
      end else begin
        check_value(32'(out_data), exp_q.pop_front(), "output pixel");
      end
    end
  end

  initial begin
    logic [31:0] rd;
    logic        err;
    int          err0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pix_valid = 1'b0;
    pix_data  = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    err0 = errors;
    check_value(32'(pix_ready), 0, "pix_ready_o after reset");
    check_value(32'(out_valid), 0, "out_valid_o after reset");
    random_coefs();
    program_coefs(5);
    for (int k = 0; k < 25; k++) begin
      apb_read(`CONV_REG_COEF(k), rd, err);
      check_value(rd, {24'h0, 8'(coef[k])}, "coefficient readback");
    end
    apb_read(`CONV_REG_SHIFT, rd, err);
    check_value(rd, 32'd5, "shift readback");
    apb_write(`CONV_REG_CTRL, 32'h3, err);
    apb_read(`CONV_REG_CTRL, rd, err);
    check_value(rd, 32'h1, "ctrl readback");
    end_test("registers", err0);

    err0 = errors;
    for (int k = 0; k < 25; k++) begin
      coef[k] = (k == 12) ? 1 : 0;
    end
    program_coefs(0);
    for (int y = 0; y < ROWS; y++) begin
      for (int x = 0; x < COLS; x++) begin
        img[y][x] = 8'((y * COLS + x) * 5 + 3);
      end
    end
    run_frame(NPIX, 1'b0, 0);
    check_value(out_cnt, NOUT, "identity output count");
    end_test("identity kernel", err0);

    err0 = errors;
    pick_random_kernel(3);
    program_coefs(3);
    run_frame(NPIX, 1'b0, 3);
    check_value(out_cnt, NOUT, "random kernel output count");
    saved_q = got_q;
    end_test("random kernel", err0);

    err0 = errors;
    apb_read(8'h0C, rd, err);
    check_value(32'(err), 1, "pslverr on read of 0x0c");
    apb_read(8'hA4, rd, err);
    check_value(32'(err), 1, "pslverr on read of 0xa4");
    apb_read(8'h06, rd, err);
    check_value(32'(err), 1, "pslverr on unaligned read");
    apb_write(8'h3C, 32'h1, err);
    check_value(32'(err), 1, "pslverr on write of 0x3c");
    apb_write(`CONV_REG_STATUS, 32'h0, err);
    check_value(32'(err), 1, "pslverr on status write");
    apb_read(`CONV_REG_STATUS, rd, err);
    check_value(32'(err), 0, "pslverr on status read");
    check_value(32'(pready), 1, "pready");
    check_value(rd, {16'(NOUT), 15'h0, 1'b1}, "status after frame");
    end_test("errors and status", err0);

    err0 = errors;
    apb_write(`CONV_REG_CTRL, 32'h0, err);
    check_value(32'(pix_ready), 0, "pix_ready_o while disabled");
    out_cnt = 0;
    send_frame(NPIX, 1'b0);
    repeat (8) @(posedge clk);
    check_value(out_cnt, 0, "outputs while disabled");
    run_frame(NPIX, 1'b1, 3);
    check_value(got_q.size(), saved_q.size(), "gap frame output count");
    foreach (got_q[i]) begin
      if (i < saved_q.size()) begin
        check_value(got_q[i], saved_q[i], "gap frame against frame without gaps");
      end
    end
    end_test("flow control", err0);

    err0 = errors;
    run_frame(4 * COLS + 6, 1'b0, 3);  // Partial frame, cut by the next restart.
    fill_random_image();
    run_frame(NPIX, 1'b0, 3);
    check_value(out_cnt, NOUT, "output count after restart");
    apb_read(`CONV_REG_STATUS, rd, err);
    check_value(rd, {16'(NOUT), 15'h0, 1'b1}, "status after restart");
    end_test("restart", err0);

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: hw/conv5x5_top.sv
`timescale 1ns/1ps

module conv5x5_top #(
  parameter int COLS = 16,
  parameter int ROWS = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [7:0]                 paddr_i,
  input  logic [31:0]                pwdata_i,
  output logic [31:0]                prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  input  logic                       pix_valid_i,
  input  logic [conv_pkg::PIX_W-1:0] pix_data_i,
  output logic                       pix_ready_o,
  output logic                       out_valid_o,
  output logic [conv_pkg::PIX_W-1:0] out_data_o
);

  logic                         enable;
  logic                         restart;
  logic                         pix_fire;
  logic                         out_fire;
  logic                         frame_last;
  logic [conv_pkg::SHIFT_W-1:0] shift;
  conv_pkg::coef_t              coefs [conv_pkg::KTAPS];

  row_tap_if rows_if ();
  window_if  win_if ();

  assign pix_ready_o = enable;
  assign pix_fire    = pix_valid_i & enable;  // Accepted pixel.

  conv_apb_regs u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .out_fire_i   (out_fire),
    .frame_last_i (frame_last),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .enable_o     (enable),
    .restart_o    (restart),
    .shift_o      (shift),
    .coefs_o      (coefs)
  );

  line_buffer #(.COLS(COLS)) u_lines (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_fire),
    .pix_data_i  (pix_data_i),
    .restart_i   (restart),
    .rows        (rows_if.src)
  );

  window_buffer #(.COLS(COLS), .ROWS(ROWS)) u_window (
    .clk          (clk),
    .rst_n        (rst_n),
    .restart_i    (restart),
    .rows         (rows_if.dst),
    .win          (win_if.src),
    .frame_last_o (frame_last)
  );

  conv_mac u_mac (
    .clk         (clk),
    .rst_n       (rst_n),
    .coefs_i     (coefs),
    .shift_i     (shift),
    .win         (win_if.dst),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_fire_o  (out_fire)
  );

endmodule

// File: hw/conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
  input  logic                         clk,
  input  logic                         rst_n,
  input  conv_pkg::coef_t              coefs_i [conv_pkg::KTAPS],
  input  logic [conv_pkg::SHIFT_W-1:0] shift_i,
  window_if.dst                        win,
  output logic                         out_valid_o,
  output conv_pkg::pix_t               out_data_o,
  output logic                         out_fire_o
);

  localparam int PW      = conv_pkg::PROD_W;
  localparam int PIX_MAX = 2**conv_pkg::PIX_W - 1;

  logic signed [PW-1:0] prod_q [conv_pkg::KTAPS];
  logic                 prod_valid_q;
  conv_pkg::acc_t       sum;
  conv_pkg::acc_t       scaled;

  // Stage 1.
  always_ff @(posedge clk) begin
    if (win.valid) begin
      for (int k = 0; k < conv_pkg::KTAPS; k++) begin
        prod_q[k] <= $signed({1'b0, win.win[k]}) * coefs_i[k];
      end
    end
  end

  always_comb begin
    sum = '0;
    for (int k = 0; k < conv_pkg::KTAPS; k++) begin
      sum = sum + conv_pkg::acc_t'(prod_q[k]);
    end
    scaled = sum >>> shift_i;  // Arithmetic.
  end

  // Stage 2 clamps into the pixel range.
  always_ff @(posedge clk) begin
    if (prod_valid_q) begin
      if (scaled < 0) begin
        out_data_o <= '0;
      end else if (scaled > conv_pkg::acc_t'(PIX_MAX)) begin
        out_data_o <= '1;
      end else begin
        out_data_o <= scaled[conv_pkg::PIX_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid_q <= 1'b0;
      out_valid_o  <= 1'b0;
    end else begin
      prod_valid_q <= win.valid;
      out_valid_o  <= prod_valid_q;
    end
  end

  assign out_fire_o = out_valid_o;  // Status counter tick.

endmodule

// File: hw/window_buffer.sv
`timescale 1ns/1ps

module window_buffer #(
  parameter int COLS = 16,
  parameter int ROWS = 12
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   restart_i,
  row_tap_if.dst rows,
  window_if.src  win,
  output logic   frame_last_o
);

  localparam int K  = conv_pkg::KSIZE;
  localparam int CW = $clog2(COLS);
  localparam int RW = $clog2(ROWS);

  conv_pkg::pix_t shift_q [K][K];  // Column K-1 is the newest.
  logic [CW-1:0]  col_q;
  logic [RW-1:0]  row_q;
  logic           col_last;
  logic           row_last;
  logic           full;

  assign col_last = (col_q == CW'(COLS - 1));
  assign row_last = (row_q == RW'(ROWS - 1));
  assign full     = (col_q >= CW'(K - 1)) && (row_q >= RW'(K - 1));

  always_ff @(posedge clk) begin
    if (!rst_n || restart_i) begin
      col_q        <= '0;
      row_q        <= '0;
      win.valid    <= 1'b0;
      frame_last_o <= 1'b0;
    end else begin
      win.valid    <= rows.valid & full;
      frame_last_o <= rows.valid & full & col_last & row_last;
      if (rows.valid) begin
        if (col_last) begin
          col_q <= '0;
          row_q <= row_last ? '0 : row_q + 1'b1;  // Ready for the next frame.
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rows.valid) begin
      for (int r = 0; r < K; r++) begin
        for (int c = 0; c < K - 1; c++) begin
          shift_q[r][c] <= shift_q[r][c+1];
        end
        shift_q[r][K-1] <= rows.taps[r];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < K; r++) begin
      for (int c = 0; c < K; c++) begin
        win.win[r*K+c] = shift_q[r][c];
      end
    end
  end

endmodule

// File: hw/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
  parameter int COLS = 16
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           pix_valid_i,
  input  conv_pkg::pix_t pix_data_i,
  input  logic           restart_i,
  row_tap_if.src         rows
);

  localparam int NLINES = conv_pkg::KSIZE - 1;
  localparam int CW     = $clog2(COLS);
  localparam int LW     = $clog2(NLINES);

  conv_pkg::pix_t line_mem [NLINES][COLS];
  logic [CW-1:0]  col_q;
  logic [LW-1:0]  oldest_q;  // Line holding the row four above the current one.

  always_ff @(posedge clk) begin
    if (!rst_n || restart_i) begin
      col_q      <= '0;
      oldest_q   <= '0;
      rows.valid <= 1'b0;
    end else begin
      rows.valid <= pix_valid_i;
      if (pix_valid_i) begin
        if (col_q == CW'(COLS - 1)) begin
          col_q    <= '0;
          oldest_q <= oldest_q + 1'b1;  // Rotate the line store.
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  // Read the four stored rows and overwrite the oldest with the new pixel.
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      for (int k = 0; k < NLINES; k++) begin
        rows.taps[k] <= line_mem[LW'(oldest_q + LW'(k))][col_q];
      end
      rows.taps[NLINES] <= pix_data_i;  // Newest row.
      line_mem[oldest_q][col_q] <= pix_data_i;
    end
  end

endmodule

// File: hw/conv_apb_regs.sv
`timescale 1ns/1ps
`include "conv_regs.svh"

module conv_apb_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [7:0]                   paddr_i,
  input  logic [31:0]                  pwdata_i,
  input  logic                         out_fire_i,
  input  logic                         frame_last_i,
  output logic [31:0]                  prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  output logic                         enable_o,
  output logic                         restart_o,
  output logic [conv_pkg::SHIFT_W-1:0] shift_o,
  output conv_pkg::coef_t              coefs_o [conv_pkg::KTAPS]
);

  localparam int IW = $clog2(conv_pkg::KTAPS);
  localparam int WW = conv_pkg::REG_WORD_W;

  logic          access;
  logic          aligned;
  logic [WW-1:0] word;
  logic          coef_hit;
  logic [IW-1:0] coef_idx;
  logic          addr_err;
  logic          wr_en;
  logic [31:0]   rdata;
  logic          frame_done_q;
  logic          last_d_q;
  logic [15:0]   out_count_q;

  assign access   = psel_i & penable_i;  // Access phase.
  assign aligned  = (paddr_i[1:0] == 2'b00);
  assign word     = paddr_i[7:2];
  assign coef_hit = (word >= conv_pkg::REG_COEF_BASE) &&
                    (word < WW'(conv_pkg::REG_COEF_BASE + conv_pkg::KTAPS));
  assign coef_idx = IW'(word - conv_pkg::REG_COEF_BASE);

  always_comb begin
    rdata    = '0;
    addr_err = 1'b0;
    case (conv_pkg::reg_addr_e'(word))
      conv_pkg::REG_CTRL: rdata[`CONV_CTRL_ENABLE_BIT] = enable_o;
      conv_pkg::REG_SHIFT: rdata[conv_pkg::SHIFT_W-1:0] = shift_o;
      conv_pkg::REG_STATUS: begin
        rdata[`CONV_STATUS_DONE_BIT] = frame_done_q;
        rdata[`CONV_STATUS_CNT_MSB:`CONV_STATUS_CNT_LSB] = out_count_q;
        addr_err = pwrite_i;  // Read-only.
      end
      default: begin
        if (coef_hit) begin
          rdata[conv_pkg::COEF_W-1:0] = coefs_o[coef_idx];
        end else begin
          addr_err = 1'b1;
        end
      end
    endcase
    if (!aligned) begin
      addr_err = 1'b1;
    end
  end

  assign prdata_o  = rdata;
  assign pready_o  = 1'b1;  // Zero wait states.
  assign pslverr_o = access & addr_err;
  assign wr_en     = access & pwrite_i & ~addr_err;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable_o  <= 1'b0;
      restart_o <= 1'b0;
      shift_o   <= '0;
      for (int k = 0; k < conv_pkg::KTAPS; k++) begin
        coefs_o[k] <= '0;
      end
    end else begin
      restart_o <= 1'b0;  // Single-cycle pulse.
      if (wr_en) begin
        case (conv_pkg::reg_addr_e'(word))
          conv_pkg::REG_CTRL: begin
            enable_o  <= pwdata_i[`CONV_CTRL_ENABLE_BIT];
            restart_o <= pwdata_i[`CONV_CTRL_RESTART_BIT];
          end
          conv_pkg::REG_SHIFT: shift_o <= pwdata_i[conv_pkg::SHIFT_W-1:0];
          default: coefs_o[coef_idx] <= pwdata_i[conv_pkg::COEF_W-1:0];
        endcase
      end
    end
  end

  // Frame-last is delayed once more to line up with the MAC output.
  always_ff @(posedge clk) begin
    if (!rst_n || restart_o) begin
      frame_done_q <= 1'b0;
      last_d_q     <= 1'b0;
      out_count_q  <= '0;
    end else begin
      last_d_q <= frame_last_i;
      if (last_d_q) begin
        frame_done_q <= 1'b1;  // Sticky.
      end
      if (out_fire_i) begin
        out_count_q <= out_count_q + 1'b1;
      end
    end
  end

endmodule

// File: hw/conv_ifs.sv
`timescale 1ns/1ps

interface row_tap_if;
  conv_pkg::pix_t taps [conv_pkg::KSIZE];  // Tap 0 is the oldest row.
  logic           valid;

  modport src (
    output taps,
    output valid
  );

  modport dst (
    input taps,
    input valid
  );
endinterface

interface window_if;
  conv_pkg::pix_t win [conv_pkg::KTAPS];  // Row-major, 0 is top-left.
  logic           valid;

  modport src (
    output win,
    output valid
  );

  modport dst (
    input win,
    input valid
  );
endinterface

// File: hw/conv_pkg.sv
package conv_pkg;

  parameter int PIX_W      = 8;
  parameter int COEF_W     = 8;
  parameter int KSIZE      = 5;
  parameter int KTAPS      = KSIZE * KSIZE;
  parameter int ACC_W      = 24;
  parameter int SHIFT_W    = 4;
  parameter int REG_WORD_W = 6;

  // Pixel zero-extended to 9 bits times a signed coefficient.
  parameter int PROD_W = PIX_W + COEF_W + 1;

  typedef logic [PIX_W-1:0]         pix_t;
  typedef logic signed [COEF_W-1:0] coef_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // Word index of each APB register, byte offset divided by four.
  typedef enum logic [REG_WORD_W-1:0] {
    REG_CTRL      = 6'd0,
    REG_SHIFT     = 6'd1,
    REG_STATUS    = 6'd2,
    REG_COEF_BASE = 6'd16
  } reg_addr_e;

endpackage

// File: include/conv_regs.svh
`ifndef CONV_REGS_SVH
`define CONV_REGS_SVH

`define CONV_REG_CTRL         8'h00
`define CONV_REG_SHIFT        8'h04
`define CONV_REG_STATUS       8'h08
`define CONV_REG_COEF_BASE    8'h40
`define CONV_REG_COEF(k)      (8'h40 + 8'((k) * 4))

`define CONV_CTRL_ENABLE_BIT  0
`define CONV_CTRL_RESTART_BIT 1

`define CONV_STATUS_DONE_BIT  0
`define CONV_STATUS_CNT_LSB   16
`define CONV_STATUS_CNT_MSB   31

`endif
